//--- rtl/bus_pkg.sv
package bus_pkg;

	// ====================================================================
	// Bus widths
	// ====================================================================

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int REGION_WIDTH = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Top address nibble selects the slave
	typedef logic [REGION_WIDTH-1:0] region_t;

	localparam region_t REGION_RAM = 4'h1;
	localparam region_t REGION_LED = 4'h4;
	localparam region_t REGION_TIMER = 4'hA;

	// ====================================================================
	// Arbiter FSM
	// ====================================================================

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY,
		ARB_RELEASE
	} arb_state_t;

endpackage

//--- rtl/periph_pkg.sv
package periph_pkg;

	// LED bank on the board
	localparam int LED_WIDTH = 10;
	typedef logic [LED_WIDTH-1:0] led_t;

	// Register index comes from address bits 4:2
	localparam int INDEX_LSB = 2;
	typedef logic [2:0] reg_index_t;

	// Timer register map
	localparam reg_index_t TMR_COUNT = 3'd0;
	localparam reg_index_t TMR_COMPARE = 3'd1;
	localparam reg_index_t TMR_CONTROL = 3'd2;
	localparam reg_index_t TMR_STATUS = 3'd3;

	// Control fields
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_IRQ_BIT = 1;

	// Status fields, write 1 to clear
	localparam int STATUS_PENDING_BIT = 0;

endpackage

//--- rtl/soc_bus_if.sv
`timescale 1ns/1ps

interface soc_bus_if;

	// Request side, held steady until ready
	logic request;
	logic rw;
	bus_pkg::addr_t address;
	bus_pkg::data_t wdata;

	// Response side, ready is a one-cycle pulse
	bus_pkg::data_t rdata;
	logic ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input rdata,
		input ready
	);

	modport slave (
		input request,
		input rw,
		input address,
		input wdata,
		output rdata,
		output ready
	);

endinterface

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input logic clock,
	input logic i_reset,

	// Port A, instruction fetch
	input logic i_pa_request,
	input bus_pkg::addr_t i_pa_address,
	output logic o_pa_ready,
	output bus_pkg::data_t o_pa_rdata,

	// Port B, data
	input logic i_pb_request,
	input logic i_pb_rw,
	input bus_pkg::addr_t i_pb_address,
	input bus_pkg::data_t i_pb_wdata,
	output logic o_pb_ready,
	output bus_pkg::data_t o_pb_rdata,

	// Port C, DMA
	input logic i_pc_request,
	input logic i_pc_rw,
	input bus_pkg::addr_t i_pc_address,
	input bus_pkg::data_t i_pc_wdata,
	output logic o_pc_ready,
	output bus_pkg::data_t o_pc_rdata,

	soc_bus_if.master bus
);

	localparam logic [1:0] GRANT_A = 2'd0;
	localparam logic [1:0] GRANT_B = 2'd1;
	localparam logic [1:0] GRANT_C = 2'd2;

	bus_pkg::arb_state_t state;
	logic [1:0] grant;
	logic [1:0] next_grant;
	logic any_request;
	logic bus_done;

	assign any_request = i_pa_request || i_pb_request || i_pc_request;

	// Fixed priority, DMA first
	always_comb
	begin
		if (i_pc_request)
			next_grant = GRANT_C;
		else if (i_pb_request)
			next_grant = GRANT_B;
		else
			next_grant = GRANT_A;
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			state <= bus_pkg::ARB_IDLE;
			grant <= GRANT_A;
			bus.request <= 1'b0;
		end
		else
		begin
			case (state)
				bus_pkg::ARB_IDLE:
				begin
					if (any_request)
					begin
						grant <= next_grant;
						bus.request <= 1'b1;
						state <= bus_pkg::ARB_BUSY;
					end
				end
				bus_pkg::ARB_BUSY:
				begin
					if (bus.ready)
					begin
						bus.request <= 1'b0;
						state <= bus_pkg::ARB_RELEASE;
					end
				end
				// One dead cycle so the slave sees request drop
				default:
					state <= bus_pkg::ARB_IDLE;
			endcase
		end
	end

	// Transfer fields are latched while idle and held through the transfer
	always_ff @(posedge clock)
	begin
		if (state == bus_pkg::ARB_IDLE)
		begin
			case (next_grant)
				GRANT_C:
				begin
					bus.rw <= i_pc_rw;
					bus.address <= i_pc_address;
					bus.wdata <= i_pc_wdata;
				end
				GRANT_B:
				begin
					bus.rw <= i_pb_rw;
					bus.address <= i_pb_address;
					bus.wdata <= i_pb_wdata;
				end
				default:
				begin
					// Fetch port only reads
					bus.rw <= 1'b0;
					bus.address <= i_pa_address;
					bus.wdata <= '0;
				end
			endcase
		end
	end

	assign bus_done = (state == bus_pkg::ARB_BUSY) && bus.ready;

	assign o_pa_ready = bus_done && (grant == GRANT_A);
	assign o_pb_ready = bus_done && (grant == GRANT_B);
	assign o_pc_ready = bus_done && (grant == GRANT_C);

	assign o_pa_rdata = (grant == GRANT_A) ? bus.rdata : '0;
	assign o_pb_rdata = (grant == GRANT_B) ? bus.rdata : '0;
	assign o_pc_rdata = (grant == GRANT_C) ? bus.rdata : '0;

endmodule

//--- rtl/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
	input logic clock,
	input logic i_reset,
	soc_bus_if.slave upstream,
	soc_bus_if.master ram_bus,
	soc_bus_if.master reg_bus
);

	localparam int OFFSET_W = bus_pkg::ADDR_WIDTH - bus_pkg::REGION_WIDTH;

	bus_pkg::region_t region;
	logic sel_ram;
	logic sel_reg;
	logic sel_none;
	logic none_ready;

	// ====================================================================
	// Region decode
	// ====================================================================

	assign region = upstream.address[bus_pkg::ADDR_WIDTH-1 -: bus_pkg::REGION_WIDTH];

	assign sel_ram = (region == bus_pkg::REGION_RAM);
	assign sel_reg = (region == bus_pkg::REGION_LED) || (region == bus_pkg::REGION_TIMER);
	assign sel_none = !sel_ram && !sel_reg;

	// RAM sees an offset within its region
	assign ram_bus.request = upstream.request && sel_ram;
	assign ram_bus.rw = upstream.rw;
	assign ram_bus.address = {{bus_pkg::REGION_WIDTH{1'b0}}, upstream.address[OFFSET_W-1:0]};
	assign ram_bus.wdata = upstream.wdata;

	// Register block serves two regions and keeps the region field
	assign reg_bus.request = upstream.request && sel_reg;
	assign reg_bus.rw = upstream.rw;
	assign reg_bus.address = upstream.address;
	assign reg_bus.wdata = upstream.wdata;

	// ====================================================================
	// Response
	// ====================================================================

	// Unmapped access completes on its own so the bus never hangs
	always_ff @(posedge clock)
	begin
		if (i_reset)
			none_ready <= 1'b0;
		else
			none_ready <= upstream.request && sel_none && !none_ready;
	end

	always_comb
	begin
		if (sel_ram)
		begin
			upstream.ready = ram_bus.ready;
			upstream.rdata = ram_bus.rdata;
		end
		else if (sel_reg)
		begin
			upstream.ready = reg_bus.ready;
			upstream.rdata = reg_bus.rdata;
		end
		else
		begin
			upstream.ready = none_ready;
			upstream.rdata = '0;
		end
	end

endmodule

//--- rtl/ram_block.sv
`timescale 1ns/1ps

module ram_block #(
	parameter int RAM_WORDS = 4096
) (
	input logic clock,
	soc_bus_if.slave bus
);

	localparam int INDEX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	bus_pkg::data_t mem [RAM_WORDS];
	logic [INDEX_W-1:0] word_index;
	logic access;
	logic ready_q;
	bus_pkg::data_t rdata_q;

	// Word addressed, wraps at the array depth
	assign word_index = INDEX_W'(bus.address[bus_pkg::ADDR_WIDTH-1:2] % RAM_WORDS);

	// Ignore the request in its ready cycle, it is still held then
	assign access = bus.request && !ready_q;

	always_ff @(posedge clock)
	begin
		ready_q <= access;
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (bus.rw)
				mem[word_index] <= bus.wdata;
			rdata_q <= mem[word_index];
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

//--- rtl/timer_led_regs.sv
`timescale 1ns/1ps

module timer_led_regs #(
	parameter int TICK_DIVIDER = 4
) (
	input logic clock,
	input logic i_reset,
	soc_bus_if.slave bus,
	output periph_pkg::led_t o_led,
	output logic o_interrupt
);

	localparam int TICK_W = (TICK_DIVIDER > 1) ? $clog2(TICK_DIVIDER) : 1;

	bus_pkg::region_t region;
	periph_pkg::reg_index_t index;
	logic is_led;
	logic is_timer;
	logic access;
	logic write;
	logic timer_write;

	periph_pkg::led_t led_q;
	logic [TICK_W-1:0] prescale;
	logic tick;
	logic match;
	bus_pkg::data_t count;
	bus_pkg::data_t compare;
	logic count_enable;
	logic irq_enable;
	logic pending;

	bus_pkg::data_t read_value;
	bus_pkg::data_t rdata_q;
	logic ready_q;

	// ====================================================================
	// Access decode
	// ====================================================================

	assign region = bus.address[bus_pkg::ADDR_WIDTH-1 -: bus_pkg::REGION_WIDTH];
	assign index = bus.address[periph_pkg::INDEX_LSB +: 3];
	assign is_led = (region == bus_pkg::REGION_LED);
	assign is_timer = (region == bus_pkg::REGION_TIMER);

	assign access = bus.request && !ready_q;
	assign write = access && bus.rw;
	assign timer_write = write && is_timer;

	// LED register answers at any offset
	always_ff @(posedge clock)
	begin
		if (i_reset)
			led_q <= '0;
		else if (write && is_led)
			led_q <= bus.wdata[periph_pkg::LED_WIDTH-1:0];
	end

	// ====================================================================
	// Timer
	// ====================================================================

	assign tick = count_enable && (prescale == TICK_W'(TICK_DIVIDER - 1));
	assign match = tick && (count == compare);

	always_ff @(posedge clock)
	begin
		if (i_reset || !count_enable || tick)
			prescale <= '0;
		else
			prescale <= prescale + 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			count <= '0;
			compare <= '0;
			count_enable <= 1'b0;
			irq_enable <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			// Restart from zero on the compare match
			if (tick)
				count <= match ? '0 : count + 1'b1;

			if (timer_write && (index == periph_pkg::TMR_COMPARE))
				compare <= bus.wdata;

			if (timer_write && (index == periph_pkg::TMR_CONTROL))
			begin
				count_enable <= bus.wdata[periph_pkg::CTRL_ENABLE_BIT];
				irq_enable <= bus.wdata[periph_pkg::CTRL_IRQ_BIT];
			end

			// A new match wins over a clear in the same cycle
			if (match)
				pending <= 1'b1;
			else if (timer_write && (index == periph_pkg::TMR_STATUS)
				&& bus.wdata[periph_pkg::STATUS_PENDING_BIT])
				pending <= 1'b0;
		end
	end

	// ====================================================================
	// Read back
	// ====================================================================

	always_comb
	begin
		read_value = '0;
		if (is_led)
			read_value[periph_pkg::LED_WIDTH-1:0] = led_q;
		else if (is_timer)
		begin
			case (index)
				periph_pkg::TMR_COUNT: read_value = count;
				periph_pkg::TMR_COMPARE: read_value = compare;
				periph_pkg::TMR_CONTROL:
				begin
					read_value[periph_pkg::CTRL_ENABLE_BIT] = count_enable;
					read_value[periph_pkg::CTRL_IRQ_BIT] = irq_enable;
				end
				periph_pkg::TMR_STATUS: read_value[periph_pkg::STATUS_PENDING_BIT] = pending;
				default: read_value = '0;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
			ready_q <= 1'b0;
		else
			ready_q <= access;
	end

	always_ff @(posedge clock)
	begin
		if (access)
			rdata_q <= read_value;
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

	assign o_led = led_q;
	assign o_interrupt = pending && irq_enable;

endmodule

//--- rtl/soc_fabric_top.sv
`timescale 1ns/1ps

module soc_fabric_top #(
	parameter int RAM_WORDS = 4096,
	parameter int TICK_DIVIDER = 4
) (
	input logic clock,
	input logic i_reset,

	// Port A, instruction fetch
	input logic i_pa_request,
	input bus_pkg::addr_t i_pa_address,
	output logic o_pa_ready,
	output bus_pkg::data_t o_pa_rdata,

	// Port B, data
	input logic i_pb_request,
	input logic i_pb_rw,
	input bus_pkg::addr_t i_pb_address,
	input bus_pkg::data_t i_pb_wdata,
	output logic o_pb_ready,
	output bus_pkg::data_t o_pb_rdata,

	// Port C, DMA
	input logic i_pc_request,
	input logic i_pc_rw,
	input bus_pkg::addr_t i_pc_address,
	input bus_pkg::data_t i_pc_wdata,
	output logic o_pc_ready,
	output bus_pkg::data_t o_pc_rdata,

	// Board outputs
	output periph_pkg::led_t o_led,
	output logic o_interrupt
);

	soc_bus_if arb_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if reg_bus ();

	bus_arbiter u_arbiter (
		.clock(clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.i_pc_request(i_pc_request),
		.i_pc_rw(i_pc_rw),
		.i_pc_address(i_pc_address),
		.i_pc_wdata(i_pc_wdata),
		.o_pc_ready(o_pc_ready),
		.o_pc_rdata(o_pc_rdata),
		.bus(arb_bus.master)
	);

	addr_decoder u_decoder (
		.clock(clock),
		.i_reset(i_reset),
		.upstream(arb_bus.slave),
		.ram_bus(ram_bus.master),
		.reg_bus(reg_bus.master)
	);

	ram_block #(
		.RAM_WORDS(RAM_WORDS)
	) u_ram (
		.clock(clock),
		.bus(ram_bus.slave)
	);

	timer_led_regs #(
		.TICK_DIVIDER(TICK_DIVIDER)
	) u_regs (
		.clock(clock),
		.i_reset(i_reset),
		.bus(reg_bus.slave),
		.o_led(o_led),
		.o_interrupt(o_interrupt)
	);

endmodule

//--- dv/soc_fabric_assert.sv
`timescale 1ns/1ps

module soc_fabric_assert (
	input logic clock,
	input logic i_reset,
	input logic i_pa_request,
	input bus_pkg::addr_t i_pa_address,
	input logic i_pa_ready,
	input logic i_pb_request,
	input bus_pkg::addr_t i_pb_address,
	input logic i_pb_ready,
	input logic i_pc_request,
	input bus_pkg::addr_t i_pc_address,
	input logic i_pc_ready,
	input logic i_interrupt
);

	int failure_count = 0;

	// ====================================================================
	// Arbitration
	// ====================================================================

	// One transfer in flight, so one ready at a time
	ready_exclusive: assert property (@(posedge clock) disable iff (i_reset)
		$onehot0({i_pa_ready, i_pb_ready, i_pc_ready}))
	else
	begin
		failure_count++;
		$error("more than one master ready in the same cycle");
	end

	pa_ready_requested: assert property (@(posedge clock) disable iff (i_reset)
		i_pa_ready |-> i_pa_request)
	else
	begin
		failure_count++;
		$error("port A ready without a request");
	end

	pb_ready_requested: assert property (@(posedge clock) disable iff (i_reset)
		i_pb_ready |-> i_pb_request)
	else
	begin
		failure_count++;
		$error("port B ready without a request");
	end

	pc_ready_requested: assert property (@(posedge clock) disable iff (i_reset)
		i_pc_ready |-> i_pc_request)
	else
	begin
		failure_count++;
		$error("port C ready without a request");
	end

	// ====================================================================
	// Requester hold and interrupt
	// ====================================================================

	pa_address_held: assert property (@(posedge clock) disable iff (i_reset)
		(i_pa_request && !i_pa_ready) |=> (i_pa_request && $stable(i_pa_address)))
	else
	begin
		failure_count++;
		$error("port A request or address changed while waiting");
	end

	pb_address_held: assert property (@(posedge clock) disable iff (i_reset)
		(i_pb_request && !i_pb_ready) |=> (i_pb_request && $stable(i_pb_address)))
	else
	begin
		failure_count++;
		$error("port B request or address changed while waiting");
	end

	pc_address_held: assert property (@(posedge clock) disable iff (i_reset)
		(i_pc_request && !i_pc_ready) |=> (i_pc_request && $stable(i_pc_address)))
	else
	begin
		failure_count++;
		$error("port C request or address changed while waiting");
	end

	interrupt_low_after_reset: assert property (@(posedge clock)
		$fell(i_reset) |-> !i_interrupt)
	else
	begin
		failure_count++;
		$error("interrupt high in the first cycle after reset");
	end

endmodule

bind soc_fabric_top soc_fabric_assert u_assert (
	.clock(clock),
	.i_reset(i_reset),
	.i_pa_request(i_pa_request),
	.i_pa_address(i_pa_address),
	.i_pa_ready(o_pa_ready),
	.i_pb_request(i_pb_request),
	.i_pb_address(i_pb_address),
	.i_pb_ready(o_pb_ready),
	.i_pc_request(i_pc_request),
	.i_pc_address(i_pc_address),
	.i_pc_ready(o_pc_ready),
	.i_interrupt(o_interrupt)
);

//--- dv/tb_soc_fabric.sv
`timescale 1ns/1ps

module tb_soc_fabric;

	localparam int WAIT_LIMIT = 50;
	localparam int IRQ_LIMIT = 400;

	localparam bus_pkg::addr_t RAM_BASE = 32'h1000_0000;
	localparam bus_pkg::addr_t LED_BASE = 32'h4000_0000;
	localparam bus_pkg::addr_t TIMER_BASE = 32'hA000_0000;

	logic clock;
	logic reset;

	logic pa_request;
	bus_pkg::addr_t pa_address;
	logic pa_ready;
	bus_pkg::data_t pa_rdata;

	logic pb_request;
	logic pb_rw;
	bus_pkg::addr_t pb_address;
	bus_pkg::data_t pb_wdata;
	logic pb_ready;
	bus_pkg::data_t pb_rdata;

	logic pc_request;
	logic pc_rw;
	bus_pkg::addr_t pc_address;
	bus_pkg::data_t pc_wdata;
	logic pc_ready;
	bus_pkg::data_t pc_rdata;

	periph_pkg::led_t led;
	logic interrupt;

	int pa_ready_count;
	int pb_ready_count;
	int pc_ready_count;

	string test_name;
	int test_errors;
	int tests_run;
	int tests_failed;

	soc_fabric_top #(
		.RAM_WORDS(4096),
		.TICK_DIVIDER(4)
	) UUT (
		.clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_ready(pa_ready),
		.o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata),
		.o_pb_ready(pb_ready),
		.o_pb_rdata(pb_rdata),
		.i_pc_request(pc_request),
		.i_pc_rw(pc_rw),
		.i_pc_address(pc_address),
		.i_pc_wdata(pc_wdata),
		.o_pc_ready(pc_ready),
		.o_pc_rdata(pc_rdata),
		.o_led(led),
		.o_interrupt(interrupt)
	);

	always #5 clock = ~clock;

	// Ready pulses per port sampled mid-cycle
	always @(negedge clock)
	begin
		if (pa_ready)
			pa_ready_count++;
		if (pb_ready)
			pb_ready_count++;
		if (pc_ready)
			pc_ready_count++;
	end

	// ====================================================================
	// Bookkeeping and checks
	// ====================================================================

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0)
			$display("Test %s passed", test_name);
		else
		begin
			tests_failed++;
			$display("Test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic check_value(input string what, input bus_pkg::data_t expected,
		input bus_pkg::data_t actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string port);
		$display("Test %s: %s got no ready within %0d cycles", test_name, port, WAIT_LIMIT);
		test_errors++;
	endtask

	function automatic bus_pkg::addr_t timer_reg(input periph_pkg::reg_index_t index);
		return TIMER_BASE | (32'(index) << 2);
	endfunction

	// ====================================================================
	// Port drivers
	// ====================================================================

	// Request stays up through the ready cycle and drops one cycle later
	task automatic fetch_word(input bus_pkg::addr_t address, output bus_pkg::data_t rdata);
		int cycles;
		cycles = 0;
		rdata = '0;
		@(negedge clock);
		pa_request = 1'b1;
		pa_address = address;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!pa_ready && cycles < WAIT_LIMIT);
		if (pa_ready)
			rdata = pa_rdata;
		else
			report_timeout("port A");
		@(negedge clock);
		pa_request = 1'b0;
	endtask

	task automatic data_access(input logic rw, input bus_pkg::addr_t address,
		input bus_pkg::data_t wdata, output bus_pkg::data_t rdata);
		int cycles;
		cycles = 0;
		rdata = '0;
		@(negedge clock);
		pb_request = 1'b1;
		pb_rw = rw;
		pb_address = address;
		pb_wdata = wdata;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!pb_ready && cycles < WAIT_LIMIT);
		if (pb_ready)
			rdata = pb_rdata;
		else
			report_timeout("port B");
		@(negedge clock);
		pb_request = 1'b0;
	endtask

	task automatic dma_access(input logic rw, input bus_pkg::addr_t address,
		input bus_pkg::data_t wdata, output bus_pkg::data_t rdata);
		int cycles;
		cycles = 0;
		rdata = '0;
		@(negedge clock);
		pc_request = 1'b1;
		pc_rw = rw;
		pc_address = address;
		pc_wdata = wdata;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!pc_ready && cycles < WAIT_LIMIT);
		if (pc_ready)
			rdata = pc_rdata;
		else
			report_timeout("port C");
		@(negedge clock);
		pc_request = 1'b0;
	endtask

	// ====================================================================
	// Tests
	// ====================================================================

	task automatic test_ram();
		bus_pkg::data_t value;
		bus_pkg::data_t rdata;
		start_test("ram_write_read");
		value = $urandom();
		data_access(1'b1, RAM_BASE + 32'h40, value, rdata);
		data_access(1'b0, RAM_BASE + 32'h40, '0, rdata);
		check_value("readback", value, rdata);
		finish_test();
	endtask

	task automatic test_fetch();
		bus_pkg::data_t expected [4];
		bus_pkg::data_t rdata;
		start_test("instruction_fetch");
		for (int i = 0; i < 4; i++)
		begin
			expected[i] = $urandom();
			data_access(1'b1, RAM_BASE + 32'h100 + 32'(4 * i), expected[i], rdata);
		end
		for (int i = 0; i < 4; i++)
		begin
			fetch_word(RAM_BASE + 32'h100 + 32'(4 * i), rdata);
			check_value("fetched word", expected[i], rdata);
		end
		finish_test();
	endtask

	task automatic test_contention();
		bus_pkg::data_t a_value;
		bus_pkg::data_t b_value;
		bus_pkg::data_t c_value;
		bus_pkg::data_t a_rdata;
		bus_pkg::data_t b_rdata;
		bus_pkg::data_t rdata;
		start_test("contention");
		a_value = $urandom();
		b_value = $urandom();
		c_value = $urandom();
		data_access(1'b1, RAM_BASE + 32'h200, b_value, rdata);
		data_access(1'b1, RAM_BASE + 32'h204, a_value, rdata);
		pa_ready_count = 0;
		pb_ready_count = 0;
		pc_ready_count = 0;
		// All three raise request on the same edge
		fork
			fetch_word(RAM_BASE + 32'h204, a_rdata);
			data_access(1'b0, RAM_BASE + 32'h200, '0, b_rdata);
			dma_access(1'b1, RAM_BASE + 32'h208, c_value, rdata);
		join
		check_value("port A read", a_value, a_rdata);
		check_value("port B read", b_value, b_rdata);
		check_value("port A ready count", 32'd1, 32'(pa_ready_count));
		check_value("port B ready count", 32'd1, 32'(pb_ready_count));
		check_value("port C ready count", 32'd1, 32'(pc_ready_count));
		dma_access(1'b0, RAM_BASE + 32'h208, '0, rdata);
		check_value("port C write", c_value, rdata);
		finish_test();
	endtask

	task automatic test_led();
		bus_pkg::data_t value;
		bus_pkg::data_t rdata;
		start_test("led_register");
		value = $urandom();
		data_access(1'b1, LED_BASE, value, rdata);
		check_value("o_led", 32'(value[9:0]), 32'(led));
		// Any offset in the region reaches the same register
		data_access(1'b0, LED_BASE + 32'h10, '0, rdata);
		check_value("LED readback", 32'(value[9:0]), rdata);
		finish_test();
	endtask

	task automatic test_timer();
		bus_pkg::data_t rdata;
		int cycles;
		start_test("timer_interrupt");
		data_access(1'b1, timer_reg(periph_pkg::TMR_COMPARE), 32'd3, rdata);
		data_access(1'b1, timer_reg(periph_pkg::TMR_CONTROL), 32'h3, rdata);
		cycles = 0;
		while (!interrupt && cycles < IRQ_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!interrupt)
		begin
			$display("Test %s: interrupt never rose within %0d cycles", test_name, IRQ_LIMIT);
			test_errors++;
		end
		data_access(1'b1, timer_reg(periph_pkg::TMR_STATUS), 32'h1, rdata);
		check_value("interrupt after clear", 32'd0, 32'(interrupt));

		// Counting on with the interrupt masked
		data_access(1'b1, timer_reg(periph_pkg::TMR_CONTROL), 32'h1, rdata);
		cycles = 0;
		rdata = '0;
		while (!rdata[0] && cycles < WAIT_LIMIT)
		begin
			data_access(1'b0, timer_reg(periph_pkg::TMR_STATUS), '0, rdata);
			cycles++;
		end
		if (!rdata[0])
		begin
			$display("Test %s: status never showed pending", test_name);
			test_errors++;
		end
		check_value("interrupt while masked", 32'd0, 32'(interrupt));
		data_access(1'b1, timer_reg(periph_pkg::TMR_CONTROL), 32'h0, rdata);
		data_access(1'b1, timer_reg(periph_pkg::TMR_STATUS), 32'h1, rdata);
		finish_test();
	endtask

	task automatic test_unmapped();
		bus_pkg::data_t value;
		bus_pkg::data_t rdata;
		start_test("unmapped_region");
		value = $urandom();
		data_access(1'b1, RAM_BASE + 32'h300, value, rdata);
		// Leaves the written word in the RAM read register
		data_access(1'b0, RAM_BASE + 32'h300, '0, rdata);
		data_access(1'b0, 32'h0000_0040, '0, rdata);
		check_value("unmapped read", 32'd0, rdata);
		data_access(1'b0, RAM_BASE + 32'h300, '0, rdata);
		check_value("RAM read after unmapped", value, rdata);
		finish_test();
	endtask

	initial
	begin
		int assert_failures;
		clock = 1'b0;
		reset = 1'b1;
		pa_request = 1'b0;
		pa_address = '0;
		pb_request = 1'b0;
		pb_rw = 1'b0;
		pb_address = '0;
		pb_wdata = '0;
		pc_request = 1'b0;
		pc_rw = 1'b0;
		pc_address = '0;
		pc_wdata = '0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'h5197_9e0d));

		repeat (5) @(negedge clock);
		reset = 1'b0;

		test_ram();
		test_fetch();
		test_contention();
		test_led();
		test_timer();
		test_unmapped();

		assert_failures = UUT.u_assert.failure_count;
		$display("Tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, assert_failures);
		if (tests_failed == 0 && assert_failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- flist.f
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/soc_bus_if.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/ram_block.sv
rtl/timer_led_regs.sv
rtl/soc_fabric_top.sv
dv/soc_fabric_assert.sv
dv/tb_soc_fabric.sv

//--- Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
TOP := tb_soc_fabric
FILELIST := flist.f
BUILD_DIR := obj_dir
LOG := sim.log
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	-./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
